/* hdl/game_pkg.sv */
`default_nettype none

package game_pkg;

    // Playfield geometry
    localparam int GRID_ROWS  = 15;
    localparam int GRID_COLS  = 20;
    localparam int GRID_CELLS = 300;

    typedef logic [3:0] level_t;
    typedef logic [1:0] cell_t;
    typedef logic [3:0] row_t;
    typedef logic [4:0] col_t;
    // Row-major index, row * 20 + col
    typedef logic [8:0] cell_idx_t;
    // Heading, clockwise turn is +1 mod 4
    typedef logic [1:0] dir_t;
    typedef logic [7:0] count_t;

    localparam cell_t CELL_BARRIER = 2'd1;

    localparam dir_t DIR_UP    = 2'd0;
    localparam dir_t DIR_RIGHT = 2'd1;
    localparam dir_t DIR_DOWN  = 2'd2;
    localparam dir_t DIR_LEFT  = 2'd3;

    // Cell (0,0) is top-left
    typedef cell_t [0:GRID_ROWS-1][0:GRID_COLS-1] barrier_map_t;

    typedef struct packed {
        logic alive;
        row_t row;
        col_t col;
        dir_t dir;
    } sprite_t;

    typedef struct packed {
        logic valid;
        row_t row;
        col_t col;
        dir_t dir;
    } spawn_t;

    typedef enum logic [1:0] {
        SPAWN_IDLE,
        SPAWN_SCAN,
        SPAWN_DONE
    } spawn_state_t;

endpackage

`default_nettype wire

/* hdl/barrier_map.sv */
`timescale 1ns/100ps
`default_nettype none

module barrier_map (
    input  wire game_pkg::level_t   level,
    output game_pkg::barrier_map_t  map
);

    // One bit per cell, column 0 is the leftmost bit
    typedef logic [0:game_pkg::GRID_COLS-1] row_mask_t;
    typedef row_mask_t [0:game_pkg::GRID_ROWS-1] level_mask_t;

    // Level 1 has the corner block and the center block
    localparam level_mask_t MASK_LEVEL1 = {
        20'b1000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0001_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000
    };

    // Level 2 adds two short walls in columns 3 and 16
    localparam level_mask_t MASK_LEVEL2 = {
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0001_0000_0000_0000_1000,
        20'b0001_0000_0000_0000_1000,
        20'b0001_0000_0000_0000_1000,
        20'b0001_0001_0000_0000_1000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000
    };

    // Any other level keeps only the center block
    localparam level_mask_t MASK_DEFAULT = {
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0001_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000,
        20'b0000_0000_0000_0000_0000
    };

    level_mask_t mask;

    // Level select
    always_comb begin
        case (level)
            4'd1:    mask = MASK_LEVEL1;
            4'd2:    mask = MASK_LEVEL2;
            default: mask = MASK_DEFAULT;
        endcase
    end

    // Expand mask bits to 2-bit cell codes
    always_comb begin
        for (int r = 0; r < game_pkg::GRID_ROWS; r++) begin
            for (int c = 0; c < game_pkg::GRID_COLS; c++) begin
                map[r][c] = mask[r][c] ? game_pkg::CELL_BARRIER : '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sprite_spawner.sv */
`timescale 1ns/100ps
`default_nettype none

module sprite_spawner #(
    parameter int                  NUM_SPRITES  = 4,
    parameter game_pkg::cell_idx_t SPAWN_STRIDE = 9'd37
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire game_pkg::level_t               level_sel,
    input  wire                                 level_start,
    input  wire game_pkg::barrier_map_t         map,
    output game_pkg::level_t                    level,
    output game_pkg::spawn_t [NUM_SPRITES-1:0]  spawns,
    output logic                                spawn_done
);

    localparam int SPRITE_W = (NUM_SPRITES > 1) ? $clog2(NUM_SPRITES) : 1;

    game_pkg::spawn_state_t state;
    logic [SPRITE_W-1:0]    sprite_idx;
    logic [SPRITE_W-1:0]    next_sprite;
    logic                   last_sprite;

    // Scan position, index plus running row and column
    game_pkg::cell_idx_t scan_idx;
    game_pkg::row_t      scan_row;
    game_pkg::col_t      scan_col;

    // Per-sprite start cell and heading, fixed at elaboration
    game_pkg::cell_idx_t [NUM_SPRITES-1:0] start_idx;
    game_pkg::row_t      [NUM_SPRITES-1:0] start_row;
    game_pkg::col_t      [NUM_SPRITES-1:0] start_col;
    game_pkg::dir_t      [NUM_SPRITES-1:0] start_dir;

    for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_start
        localparam int START = (g * SPAWN_STRIDE) % game_pkg::GRID_CELLS;
        assign start_idx[g] = game_pkg::cell_idx_t'(START);
        assign start_row[g] = game_pkg::row_t'(START / game_pkg::GRID_COLS);
        assign start_col[g] = game_pkg::col_t'(START % game_pkg::GRID_COLS);
        assign start_dir[g] = game_pkg::dir_t'(g % 4);
    end

    assign next_sprite = sprite_idx + SPRITE_W'(1);
    assign last_sprite = (sprite_idx == SPRITE_W'(NUM_SPRITES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= game_pkg::SPAWN_IDLE;
            level      <= '0;
            spawn_done <= 1'b0;
            sprite_idx <= '0;
            scan_idx   <= '0;
            scan_row   <= '0;
            scan_col   <= '0;
            spawns     <= '0;
        end else begin
            // Spawn strobes last one cycle
            for (int k = 0; k < NUM_SPRITES; k++) begin
                spawns[k].valid <= 1'b0;
            end
            if (level_start) begin
                // New level, restart from sprite 0
                level      <= level_sel;
                spawn_done <= 1'b0;
                state      <= game_pkg::SPAWN_SCAN;
                sprite_idx <= '0;
                scan_idx   <= start_idx[0];
                scan_row   <= start_row[0];
                scan_col   <= start_col[0];
            end else begin
                case (state)
                    game_pkg::SPAWN_SCAN: begin
                        if (map[scan_row][scan_col] != game_pkg::CELL_BARRIER) begin
                            // Free cell found
                            spawns[sprite_idx] <= '{valid: 1'b1, row: scan_row,
                                                    col: scan_col,
                                                    dir: start_dir[sprite_idx]};
                            if (last_sprite) begin
                                state <= game_pkg::SPAWN_DONE;
                            end else begin
                                sprite_idx <= next_sprite;
                                scan_idx   <= start_idx[next_sprite];
                                scan_row   <= start_row[next_sprite];
                                scan_col   <= start_col[next_sprite];
                            end
                        end else if (scan_idx == game_pkg::cell_idx_t'(game_pkg::GRID_CELLS - 1)) begin
                            // Wrap from the last cell to the first
                            scan_idx <= '0;
                            scan_row <= '0;
                            scan_col <= '0;
                        end else if (scan_col == game_pkg::col_t'(game_pkg::GRID_COLS - 1)) begin
                            scan_idx <= scan_idx + 9'd1;
                            scan_row <= scan_row + 4'd1;
                            scan_col <= '0;
                        end else begin
                            scan_idx <= scan_idx + 9'd1;
                            scan_col <= scan_col + 5'd1;
                        end
                    end
                    game_pkg::SPAWN_DONE: begin
                        // One cycle after the last strobe
                        spawn_done <= 1'b1;
                        state      <= game_pkg::SPAWN_IDLE;
                    end
                    default: begin
                        state <= game_pkg::SPAWN_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sprite_mover.sv */
`timescale 1ns/100ps
`default_nettype none

module sprite_mover (
    input  wire                          clk,
    input  wire                          rst,
    input  wire game_pkg::spawn_t        spawn,
    input  wire                          move_tick,
    input  wire                          kill,
    input  wire game_pkg::barrier_map_t  map,
    output game_pkg::sprite_t            sprite
);

    game_pkg::row_t next_row;
    game_pkg::col_t next_col;
    logic           off_grid;
    logic           blocked;

    // Neighbor cell in the current heading
    always_comb begin
        next_row = sprite.row;
        next_col = sprite.col;
        off_grid = 1'b0;
        case (sprite.dir)
            game_pkg::DIR_UP: begin
                if (sprite.row == '0) off_grid = 1'b1;
                else next_row = sprite.row - 4'd1;
            end
            game_pkg::DIR_RIGHT: begin
                if (sprite.col == game_pkg::col_t'(game_pkg::GRID_COLS - 1)) off_grid = 1'b1;
                else next_col = sprite.col + 5'd1;
            end
            game_pkg::DIR_DOWN: begin
                if (sprite.row == game_pkg::row_t'(game_pkg::GRID_ROWS - 1)) off_grid = 1'b1;
                else next_row = sprite.row + 4'd1;
            end
            default: begin
                // Heading left
                if (sprite.col == '0) off_grid = 1'b1;
                else next_col = sprite.col - 5'd1;
            end
        endcase
        // Edge or barrier ahead means turn
        blocked = off_grid || (map[next_row][next_col] == game_pkg::CELL_BARRIER);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sprite <= '0;
        end else if (spawn.valid) begin
            // Respawn wins over a stale kill
            sprite.alive <= 1'b1;
            sprite.row   <= spawn.row;
            sprite.col   <= spawn.col;
            sprite.dir   <= spawn.dir;
        end else if (kill) begin
            sprite.alive <= 1'b0;
        end else if (move_tick && sprite.alive) begin
            if (blocked) begin
                // Clockwise turn in place
                sprite.dir <= sprite.dir + 2'd1;
            end else begin
                sprite.row <= next_row;
                sprite.col <= next_col;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/hit_detector.sv */
`timescale 1ns/100ps
`default_nettype none

module hit_detector #(
    parameter int NUM_SPRITES = 4
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      level_start,
    input  wire game_pkg::sprite_t [NUM_SPRITES-1:0] sprites,
    input  wire game_pkg::row_t                      player_row,
    input  wire game_pkg::col_t                      player_col,
    input  wire game_pkg::barrier_map_t              map,
    output logic [NUM_SPRITES-1:0]                   kill,
    output logic                                     hit,
    output game_pkg::count_t                         hit_count,
    output game_pkg::count_t                         alive_count,
    output logic                                     player_blocked
);

    logic [NUM_SPRITES-1:0] touch;
    game_pkg::count_t       touch_num;
    game_pkg::count_t       alive_num;
    logic [8:0]             hit_sum;

    // Parallel compare against the player cell
    always_comb begin
        touch_num = '0;
        alive_num = '0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            // Skip sprites already being killed
            touch[i] = sprites[i].alive && !kill[i] &&
                       (sprites[i].row == player_row) && (sprites[i].col == player_col);
            touch_num = touch_num + game_pkg::count_t'(touch[i]);
            alive_num = alive_num + game_pkg::count_t'(sprites[i].alive);
        end
    end

    // Saturating hit total
    assign hit_sum = {1'b0, hit_count} + {1'b0, touch_num};

    always_ff @(posedge clk) begin
        if (rst) begin
            kill        <= '0;
            hit         <= 1'b0;
            hit_count   <= '0;
            alive_count <= '0;
        end else begin
            kill        <= touch;
            hit         <= |touch;
            alive_count <= alive_num;
            if (level_start) hit_count <= '0;
            else hit_count <= hit_sum[8] ? 8'hff : hit_sum[7:0];
        end
    end

    assign player_blocked = (map[player_row][player_col] == game_pkg::CELL_BARRIER);

endmodule

`default_nettype wire

/* hdl/game_core.sv */
`timescale 1ns/100ps
`default_nettype none

module game_core #(
    parameter int                  NUM_SPRITES  = 4,
    parameter game_pkg::cell_idx_t SPAWN_STRIDE = 9'd37
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire game_pkg::level_t                level_sel,
    input  wire                                  level_start,
    input  wire                                  move_tick,
    input  wire game_pkg::row_t                  player_row,
    input  wire game_pkg::col_t                  player_col,
    output game_pkg::sprite_t [NUM_SPRITES-1:0]  sprites,
    output logic                                 spawn_done,
    output logic                                 player_blocked,
    output logic                                 hit,
    output game_pkg::count_t                     hit_count,
    output game_pkg::count_t                     alive_count
);

    game_pkg::level_t                   level;
    game_pkg::barrier_map_t             map;
    game_pkg::spawn_t [NUM_SPRITES-1:0] spawns;
    logic [NUM_SPRITES-1:0]             kill;

    // Map for the latched level
    barrier_map u_barrier_map (
        .level (level),
        .map   (map)
    );

    sprite_spawner #(
        .NUM_SPRITES  (NUM_SPRITES),
        .SPAWN_STRIDE (SPAWN_STRIDE)
    ) u_sprite_spawner (
        .clk         (clk),
        .rst         (rst),
        .level_sel   (level_sel),
        .level_start (level_start),
        .map         (map),
        .level       (level),
        .spawns      (spawns),
        .spawn_done  (spawn_done)
    );

    // One mover per sprite
    for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_mover
        sprite_mover u_sprite_mover (
            .clk       (clk),
            .rst       (rst),
            .spawn     (spawns[g]),
            .move_tick (move_tick),
            .kill      (kill[g]),
            .map       (map),
            .sprite    (sprites[g])
        );
    end

    hit_detector #(
        .NUM_SPRITES (NUM_SPRITES)
    ) u_hit_detector (
        .clk            (clk),
        .rst            (rst),
        .level_start    (level_start),
        .sprites        (sprites),
        .player_row     (player_row),
        .player_col     (player_col),
        .map            (map),
        .kill           (kill),
        .hit            (hit),
        .hit_count      (hit_count),
        .alive_count    (alive_count),
        .player_blocked (player_blocked)
    );

endmodule

`default_nettype wire

/* sim/game_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module game_core_tb;

    localparam int NUM_SPRITES   = 4;
    localparam int SPAWN_STRIDE  = 37;
    localparam int CLK_PERIOD    = 40;
    localparam int NUM_TESTS     = 6;
    localparam int SPAWN_TIMEOUT = 1000;
    // 400 cycles per test plus 2000
    localparam int WATCHDOG_NS   = (400 * NUM_TESTS + 2000) * CLK_PERIOD;
    // Known barrier cells probed on every level
    localparam int PROBE_ROW [4] = '{0, 7, 4, 6};
    localparam int PROBE_COL [4] = '{0, 7, 3, 16};

    logic                                 clk = 1'b0;
    logic                                 rst;
    game_pkg::level_t                     level_sel;
    logic                                 level_start;
    logic                                 move_tick;
    game_pkg::row_t                       player_row;
    game_pkg::col_t                       player_col;
    game_pkg::sprite_t [NUM_SPRITES-1:0]  sprites;
    logic                                 spawn_done;
    logic                                 player_blocked;
    logic                                 hit;
    game_pkg::count_t                     hit_count;
    game_pkg::count_t                     alive_count;

    // Model copy of the sprites and bookkeeping
    game_pkg::sprite_t model [NUM_SPRITES];
    int                model_hits = 0;
    logic              check_req;
    int                cur_level;
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                failed = 0;
    int                errors_at_start = 0;

    game_core dut (
        .clk            (clk),
        .rst            (rst),
        .level_sel      (level_sel),
        .level_start    (level_start),
        .move_tick      (move_tick),
        .player_row     (player_row),
        .player_col     (player_col),
        .sprites        (sprites),
        .spawn_done     (spawn_done),
        .player_blocked (player_blocked),
        .hit            (hit),
        .hit_count      (hit_count),
        .alive_count    (alive_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Three map rules sharing the (7,7) barrier
    function automatic bit barrier_at(input int level, input int row, input int col);
        bit center;
        bit result;
        center = (row == 7) && (col == 7);
        case (level)
            1:       result = center || (row == 0 && col == 0);
            2:       result = center || ((col == 3 || col == 16) && row >= 4 && row <= 7);
            default: result = center;
        endcase
        return result;
    endfunction

    // First free cell at or after i * stride with wrap at the last cell
    function automatic game_pkg::sprite_t expected_spawn(input int level, input int i);
        int                idx;
        game_pkg::sprite_t s;
        idx = (i * SPAWN_STRIDE) % game_pkg::GRID_CELLS;
        while (barrier_at(level, idx / game_pkg::GRID_COLS, idx % game_pkg::GRID_COLS)) begin
            idx = (idx + 1) % game_pkg::GRID_CELLS;
        end
        s.alive = 1'b1;
        s.row   = game_pkg::row_t'(idx / game_pkg::GRID_COLS);
        s.col   = game_pkg::col_t'(idx % game_pkg::GRID_COLS);
        s.dir   = game_pkg::dir_t'(i % 4);
        return s;
    endfunction

    // One step ahead or a clockwise turn at an edge or barrier
    function automatic game_pkg::sprite_t step(input game_pkg::sprite_t s, input int level);
        int                r;
        int                c;
        game_pkg::sprite_t n;
        n = s;
        r = int'(s.row);
        c = int'(s.col);
        case (s.dir)
            2'd0:    r = r - 1;
            2'd1:    c = c + 1;
            2'd2:    r = r + 1;
            default: c = c - 1;
        endcase
        if (r < 0 || r >= game_pkg::GRID_ROWS || c < 0 || c >= game_pkg::GRID_COLS ||
            barrier_at(level, r, c)) begin
            n.dir = s.dir + 2'd1;
        end else begin
            n.row = game_pkg::row_t'(r);
            n.col = game_pkg::col_t'(c);
        end
        return n;
    endfunction

    function automatic bit occupied(input int r, input int c);
        bit found;
        found = 1'b0;
        for (int k = 0; k < NUM_SPRITES; k++) begin
            if (model[k].alive && int'(model[k].row) == r && int'(model[k].col) == c) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    function automatic int count_alive();
        int n;
        n = 0;
        for (int k = 0; k < NUM_SPRITES; k++) begin
            n = n + int'(model[k].alive);
        end
        return n;
    endfunction

    // Compare all sprites once per request
    always @(negedge clk) begin
        if (check_req) begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
                checks++;
                assert (sprites[i] == model[i]) else begin
                    errors++;
                    $display("mismatch at %0t: sprite %0d alive %0b (%0d,%0d) dir %0d,", $time,
                             i, sprites[i].alive, sprites[i].row, sprites[i].col, sprites[i].dir);
                    $display("    expected alive %0b (%0d,%0d) dir %0d", model[i].alive,
                             model[i].row, model[i].col, model[i].dir);
                end
            end
        end
    end

    task automatic check_value(input string what, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic compare_sprites();
        @(posedge clk);
        check_req <= 1'b1;
        @(posedge clk);
        check_req <= 1'b0;
        @(negedge clk);
    endtask

    task automatic set_player(input int r, input int c);
        @(posedge clk);
        player_row <= game_pkg::row_t'(r);
        player_col <= game_pkg::col_t'(c);
        @(negedge clk);
    endtask

    task automatic wait_spawn_done();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!spawn_done && n < SPAWN_TIMEOUT);
        checks++;
        assert (spawn_done) else begin
            errors++;
            $display("spawn_done never rose within %0d cycles of level_start", SPAWN_TIMEOUT);
        end
    endtask

    // Pulse level_start and load the expected spawn cells
    task automatic start_level(input int level);
        @(posedge clk);
        level_sel   <= game_pkg::level_t'(level);
        level_start <= 1'b1;
        @(posedge clk);
        level_start <= 1'b0;
        wait_spawn_done();
        cur_level = level;
        // Hit total starts again from zero
        model_hits = 0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            model[i] = expected_spawn(level, i);
        end
    endtask

    // Tick after a random gap and step the model along
    task automatic tick_once();
        repeat ($urandom_range(1, 5)) @(posedge clk);
        move_tick <= 1'b1;
        @(posedge clk);
        move_tick <= 1'b0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            if (model[i].alive) begin
                model[i] = step(model[i], cur_level);
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: pass", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: FAIL (%0d errors)", tests, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin : stimulus
        int                r;
        int                c;
        int                n;
        int                n_hit;
        bit                found;
        game_pkg::sprite_t nxt;
        void'($urandom(32'hfd6e40d7));
        rst         = 1'b1;
        level_sel   = '0;
        level_start = 1'b0;
        move_tick   = 1'b0;
        // Player parked on the center barrier where no sprite can go
        player_row  = 4'd7;
        player_col  = 5'd7;
        check_req   = 1'b0;
        cur_level   = 0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // Test 1 covers idle outputs after reset
        check_value("spawn_done", int'(spawn_done), 0);
        check_value("hit", int'(hit), 0);
        check_value("hit_count", int'(hit_count), 0);
        check_value("alive_count", int'(alive_count), 0);
        check_value("player_blocked", int'(player_blocked), int'(barrier_at(0, 7, 7)));
        compare_sprites();
        finish_test("reset state");

        // Test 2 covers spawn cells on each map
        for (int lv = 0; lv < 3; lv++) begin
            start_level(lv);
            compare_sprites();
            check_value("alive_count", int'(alive_count), NUM_SPRITES);
        end
        finish_test("spawn placement");

        // Test 3 covers barrier lookup at player cells away from sprites
        for (int lv = 0; lv < 3; lv++) begin
            start_level(lv);
            for (int k = 0; k < 20; k++) begin
                if (k < 4) begin
                    r = PROBE_ROW[k];
                    c = PROBE_COL[k];
                end else begin
                    r = int'($urandom_range(0, game_pkg::GRID_ROWS - 1));
                    c = int'($urandom_range(0, game_pkg::GRID_COLS - 1));
                end
                if (!occupied(r, c)) begin
                    set_player(r, c);
                    check_value("player_blocked", int'(player_blocked),
                                int'(barrier_at(lv, r, c)));
                end
            end
            set_player(7, 7);
        end
        finish_test("player blocked");

        // Test 4 covers the sprite walk on level 2
        for (int t = 0; t < 60; t++) begin
            tick_once();
            compare_sprites();
        end
        finish_test("move ticks");

        // Test 5 parks the player on a free cell that a sprite enters next
        found = 1'b0;
        r = 0;
        c = 0;
        for (int attempt = 0; attempt < 8 && !found; attempt++) begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
                nxt = step(model[i], cur_level);
                if (!found && model[i].alive && !occupied(int'(nxt.row), int'(nxt.col))) begin
                    found = 1'b1;
                    r = int'(nxt.row);
                    c = int'(nxt.col);
                end
            end
            if (!found) begin
                tick_once();
            end
        end
        checks++;
        assert (found) else begin
            errors++;
            $display("no sprite heads into a free cell within 8 ticks");
        end
        n_hit = 0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            nxt = step(model[i], cur_level);
            if (model[i].alive && int'(nxt.row) == r && int'(nxt.col) == c) begin
                n_hit++;
            end
        end
        // Hit total saturates at 255
        model_hits = (model_hits + n_hit > 255) ? 255 : model_hits + n_hit;
        set_player(r, c);
        tick_once();
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!hit && n < 10);
        checks++;
        assert (hit) else begin
            errors++;
            $display("hit never pulsed after a sprite entered the player cell");
        end
        check_value("hit_count", int'(hit_count), model_hits);
        for (int i = 0; i < NUM_SPRITES; i++) begin
            if (model[i].alive && int'(model[i].row) == r && int'(model[i].col) == c) begin
                model[i].alive = 1'b0;
            end
        end
        // Alive clears one edge after kill and the count one edge later
        @(negedge clk);
        @(negedge clk);
        check_value("alive_count", int'(alive_count), count_alive());
        compare_sprites();
        finish_test("player hit");

        // Test 6 checks that a restart clears hits and revives every sprite
        set_player(7, 7);
        start_level(2);
        check_value("hit_count", int'(hit_count), model_hits);
        compare_sprites();
        check_value("alive_count", int'(alive_count), NUM_SPRITES);
        finish_test("level restart");

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests, failed, checks, errors);
        if (failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Run limit from the test count
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/game_pkg.sv
hdl/barrier_map.sv
hdl/sprite_spawner.sv
hdl/sprite_mover.sv
hdl/hit_detector.sv
hdl/game_core.sv
sim/game_core_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := game_core_tb
RTL_TOP   := game_core
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

# Lint the RTL on its own, then the testbench together with it
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
